// File: src/layer_pkg.sv
//==========================================================
// layer types and channel counts seen by the preheat decoder
// channel counts are real counts, zero means no channel
//==========================================================

package layer_pkg;

    //==========================================================
    // layer type, encoding follows the layer descriptor
    //==========================================================
    typedef enum logic [1:0] {
        POINTWISE = 2'd0,   // 1x1 conv
        DEPTHWISE = 2'd1,   // one 3x3 filter per channel
        STANDARD  = 2'd2,   // full 3x3 conv
        LINEAR    = 2'd3    // fully connected
    } layer_type_e;

    // real input or output channel count of the layer
    typedef logic [7:0] ch_cnt_t;

    // kernel rows that feed one input channel in 3x3 layers
    localparam int KERNEL_ROWS = 3;

endpackage : layer_pkg

// File: src/fifo_pkg.sv
//==========================================================
// types shared by the FIFO facing preheat blocks
// pop counts assume at most 32 FIFOs per side
//==========================================================

package fifo_pkg;

    // pops one FIFO needs, worst case is 33 with 32 FIFOs
    typedef logic [5:0] pop_cnt_t;

    // pops over all FIFOs of one side in one preheat
    typedef logic [15:0] pop_total_t;

endpackage : fifo_pkg

// File: src/preheat_if.sv
//==========================================================
// pop plan from decoder to engine, progress from engine
// plan masks and counts are only meaningful while load is high
//==========================================================
`timescale 1ns/1ps

interface preheat_plan_if #(
    parameter int NUM_IFMAP_FIFO = 32,
    parameter int NUM_IPSUM_FIFO = 32
);
    import fifo_pkg::*;

    logic                                 load;        // one cycle strobe
    logic     [NUM_IFMAP_FIFO-1:0]        ifmap_mask;
    pop_cnt_t [NUM_IFMAP_FIFO-1:0]        ifmap_cnt;
    logic     [NUM_IPSUM_FIFO-1:0]        ipsum_mask;
    pop_cnt_t [NUM_IPSUM_FIFO-1:0]        ipsum_cnt;

    modport decode (output load, ifmap_mask, ifmap_cnt, ipsum_mask, ipsum_cnt);
    modport engine (input  load, ifmap_mask, ifmap_cnt, ipsum_mask, ipsum_cnt);

endinterface : preheat_plan_if

interface fifo_prog_if #(
    parameter int NUM_IFMAP_FIFO = 32,
    parameter int NUM_IPSUM_FIFO = 32
);

    logic [NUM_IFMAP_FIFO-1:0] ifmap_pop;    // pop strobes
    logic [NUM_IPSUM_FIFO-1:0] ipsum_pop;
    logic [NUM_IFMAP_FIFO-1:0] ifmap_done;   // counter at zero
    logic [NUM_IPSUM_FIFO-1:0] ipsum_done;

    modport engine (output ifmap_pop, ipsum_pop, ifmap_done, ipsum_done);
    modport ctrl   (input  ifmap_done, ipsum_done);
    modport status (input  ifmap_pop, ipsum_pop);

endinterface : fifo_prog_if

// File: src/layer_decode.sv
//==========================================================
// registered pop plan decoder, load follows set phase by one cycle
// enabled FIFOs are capped at the FIFO count of each side
//==========================================================
`timescale 1ns/1ps

module layer_decode #(
    parameter int NUM_IFMAP_FIFO = 32,
    parameter int NUM_IPSUM_FIFO = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  set_phase_i,
    input  layer_pkg::layer_type_e layer_type_i,
    input  layer_pkg::ch_cnt_t    ic_real_i,
    input  layer_pkg::ch_cnt_t    oc_real_i,
    preheat_plan_if.decode        plan
);
    import layer_pkg::*;
    import fifo_pkg::*;

    logic [9:0]                        ic_span;      // ifmap FIFOs the layer wants
    logic     [NUM_IFMAP_FIFO-1:0]     ifmap_mask_d;
    pop_cnt_t [NUM_IFMAP_FIFO-1:0]     ifmap_cnt_d;
    logic     [NUM_IPSUM_FIFO-1:0]     ipsum_mask_d;
    pop_cnt_t [NUM_IPSUM_FIFO-1:0]     ipsum_cnt_d;

    //==========================================================
    // ifmap side, 3x3 layers spread each channel over 3 rows
    //==========================================================
    always_comb begin
        if (layer_type_i == DEPTHWISE || layer_type_i == STANDARD)
            ic_span = 10'(ic_real_i) * 10'(KERNEL_ROWS);
        else
            ic_span = 10'(ic_real_i);

        ifmap_mask_d = '0;
        ifmap_cnt_d  = '0;
        for (int j = 0; j < NUM_IFMAP_FIFO; j++) begin
            if (j < int'(ic_span)) begin
                ifmap_mask_d[j] = 1'b1;
                case (layer_type_i)
                    DEPTHWISE: ifmap_cnt_d[j] = pop_cnt_t'((j / KERNEL_ROWS + 1) * KERNEL_ROWS);
                    STANDARD:  ifmap_cnt_d[j] = pop_cnt_t'(KERNEL_ROWS);
                    default:   ifmap_cnt_d[j] = pop_cnt_t'(1);  // pointwise, linear
                endcase
            end
        end
    end

    // ipsum side, one pop per output channel for every layer type
    always_comb begin
        ipsum_mask_d = '0;
        ipsum_cnt_d  = '0;
        for (int k = 0; k < NUM_IPSUM_FIFO; k++) begin
            if (k < int'(oc_real_i)) begin
                ipsum_mask_d[k] = 1'b1;
                ipsum_cnt_d[k]  = pop_cnt_t'(1);
            end
        end
    end

    //==========================================================
    // plan register, empty outside the load cycle
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plan.load       <= 1'b0;
            plan.ifmap_mask <= '0;
            plan.ifmap_cnt  <= '0;
            plan.ipsum_mask <= '0;
            plan.ipsum_cnt  <= '0;
        end else begin
            plan.load       <= set_phase_i;
            plan.ifmap_mask <= set_phase_i ? ifmap_mask_d : '0;
            plan.ifmap_cnt  <= set_phase_i ? ifmap_cnt_d  : '0;
            plan.ipsum_mask <= set_phase_i ? ipsum_mask_d : '0;
            plan.ipsum_cnt  <= set_phase_i ? ipsum_cnt_d  : '0;
        end
    end

    // the engine trusts the counts, so a masked FIFO must carry zero
    for (genvar g = 0; g < NUM_IFMAP_FIFO; g++) begin : g_ifmap_chk
        a_ifmap_cnt_masked: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.ifmap_mask[g] |-> plan.ifmap_cnt[g] == '0)
            else $error("ifmap count without mask bit");
    end
    for (genvar g = 0; g < NUM_IPSUM_FIFO; g++) begin : g_ipsum_chk
        a_ipsum_cnt_masked: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.ipsum_mask[g] |-> plan.ipsum_cnt[g] == '0)
            else $error("ipsum count without mask bit");
    end

endmodule : layer_decode

// File: src/preheat_ctrl.sv
//==========================================================
// preheat FSM, idle -> set -> wait -> done -> idle
// start is only looked at in idle
//==========================================================
`timescale 1ns/1ps

module preheat_ctrl (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_preheat_i,
    fifo_prog_if.ctrl   prog,
    output logic        set_phase_o,
    output logic        busy_o,
    output logic        opsum_push_one_o,
    output logic        preheat_done_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SET,      // decoder builds the plan
        ST_WAIT,     // engine pops until all counters drain
        ST_DONE
    } state_e;

    state_e state_q, state_d;
    logic   all_done;

    assign all_done = (&prog.ifmap_done) && (&prog.ipsum_done);

    //==========================================================
    // state register and next state
    //==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: if (start_preheat_i) state_d = ST_SET;
            ST_SET:  state_d = ST_WAIT;                      // exactly one cycle
            ST_WAIT: if (all_done) state_d = ST_DONE;
            ST_DONE: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    // outputs decoded from state
    assign set_phase_o      = (state_q == ST_SET);
    assign busy_o           = (state_q != ST_IDLE);
    assign preheat_done_o   = (state_q == ST_DONE);
    assign opsum_push_one_o = (state_q == ST_DONE);  // one opsum push after preheat

    // every start must give one isolated done pulse
    a_done_single: assert property (@(posedge clk) disable iff (!rst_n)
        preheat_done_o |=> !preheat_done_o)
        else $error("preheat done pulse longer than one cycle");

endmodule : preheat_ctrl

// File: src/fifo_pop_engine.sv
//==========================================================
// one down-counter per FIFO, a pop costs one count
// the load cycle already pops from the fresh plan
//==========================================================
`timescale 1ns/1ps

module fifo_pop_engine #(
    parameter int NUM_IFMAP_FIFO = 32,
    parameter int NUM_IPSUM_FIFO = 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [NUM_IFMAP_FIFO-1:0] ifmap_ready_i,
    input  logic [NUM_IPSUM_FIFO-1:0] ipsum_ready_i,
    preheat_plan_if.engine            plan,
    fifo_prog_if.engine               prog
);
    import fifo_pkg::*;

    pop_cnt_t [NUM_IFMAP_FIFO-1:0] ifmap_cnt_q;
    pop_cnt_t [NUM_IFMAP_FIFO-1:0] ifmap_cur;     // count seen this cycle
    pop_cnt_t [NUM_IFMAP_FIFO-1:0] ifmap_cnt_d;
    pop_cnt_t [NUM_IPSUM_FIFO-1:0] ipsum_cnt_q;
    pop_cnt_t [NUM_IPSUM_FIFO-1:0] ipsum_cur;
    pop_cnt_t [NUM_IPSUM_FIFO-1:0] ipsum_cnt_d;
    logic     [NUM_IFMAP_FIFO-1:0] ifmap_pop;
    logic     [NUM_IFMAP_FIFO-1:0] ifmap_done;
    logic     [NUM_IPSUM_FIFO-1:0] ipsum_pop;
    logic     [NUM_IPSUM_FIFO-1:0] ipsum_done;

    // plan count on load, otherwise what is left in the counter
    function automatic pop_cnt_t cur_cnt(input logic     load,
                                         input logic     en,
                                         input pop_cnt_t plan_cnt,
                                         input pop_cnt_t held);
        if (load)
            return en ? plan_cnt : '0;
        return held;
    endfunction

    //==========================================================
    // pop decision, ready low simply holds the count
    //==========================================================
    always_comb begin
        for (int i = 0; i < NUM_IFMAP_FIFO; i++) begin
            ifmap_cur[i]   = cur_cnt(plan.load, plan.ifmap_mask[i], plan.ifmap_cnt[i],
                                     ifmap_cnt_q[i]);
            ifmap_done[i]  = (ifmap_cur[i] == '0);
            ifmap_pop[i]   = !ifmap_done[i] && ifmap_ready_i[i];
            ifmap_cnt_d[i] = ifmap_cur[i] - pop_cnt_t'(ifmap_pop[i]);
        end
        for (int i = 0; i < NUM_IPSUM_FIFO; i++) begin
            ipsum_cur[i]   = cur_cnt(plan.load, plan.ipsum_mask[i], plan.ipsum_cnt[i],
                                     ipsum_cnt_q[i]);
            ipsum_done[i]  = (ipsum_cur[i] == '0);
            ipsum_pop[i]   = !ipsum_done[i] && ipsum_ready_i[i];
            ipsum_cnt_d[i] = ipsum_cur[i] - pop_cnt_t'(ipsum_pop[i]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_cnt_q <= '0;
            ipsum_cnt_q <= '0;
        end else begin
            ifmap_cnt_q <= ifmap_cnt_d;
            ipsum_cnt_q <= ipsum_cnt_d;
        end
    end

    assign prog.ifmap_pop  = ifmap_pop;
    assign prog.ipsum_pop  = ipsum_pop;
    assign prog.ifmap_done = ifmap_done;
    assign prog.ipsum_done = ipsum_done;

    //==========================================================
    // checks on the counters behind the strobes
    //==========================================================
    for (genvar g = 0; g < NUM_IFMAP_FIFO; g++) begin : g_ifmap_chk
        // a FIFO that is not ready keeps its count, so it was not popped
        a_ifmap_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.load && !ifmap_ready_i[g] |=> ifmap_cnt_q[g] == $past(ifmap_cnt_q[g]))
            else $error("ifmap counter moved while its FIFO was not ready");
        a_ifmap_drained_quiet: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.load && ifmap_cnt_q[g] == '0 |-> !prog.ifmap_pop[g])
            else $error("ifmap pop issued from a drained counter");
    end
    for (genvar g = 0; g < NUM_IPSUM_FIFO; g++) begin : g_ipsum_chk
        a_ipsum_stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.load && !ipsum_ready_i[g] |=> ipsum_cnt_q[g] == $past(ipsum_cnt_q[g]))
            else $error("ipsum counter moved while its FIFO was not ready");
        a_ipsum_drained_quiet: assert property (@(posedge clk) disable iff (!rst_n)
            !plan.load && ipsum_cnt_q[g] == '0 |-> !prog.ipsum_pop[g])
            else $error("ipsum pop issued from a drained counter");
    end

endmodule : fifo_pop_engine

// File: src/preheat_status.sv
//==========================================================
// running pop totals of one preheat, cleared in the set cycle
// totals hold after done until the next start
//==========================================================
`timescale 1ns/1ps

module preheat_status #(
    parameter int NUM_IFMAP_FIFO = 32,
    parameter int NUM_IPSUM_FIFO = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   set_phase_i,
    fifo_prog_if.status            prog,
    output fifo_pkg::pop_total_t   ifmap_pop_total_o,
    output fifo_pkg::pop_total_t   ipsum_pop_total_o
);
    import fifo_pkg::*;

    pop_total_t ifmap_inc;   // pops this cycle
    pop_total_t ipsum_inc;

    // population count of each pop vector
    always_comb begin
        ifmap_inc = '0;
        ipsum_inc = '0;
        for (int i = 0; i < NUM_IFMAP_FIFO; i++)
            ifmap_inc = ifmap_inc + pop_total_t'(prog.ifmap_pop[i]);
        for (int i = 0; i < NUM_IPSUM_FIFO; i++)
            ipsum_inc = ipsum_inc + pop_total_t'(prog.ipsum_pop[i]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifmap_pop_total_o <= '0;
            ipsum_pop_total_o <= '0;
        end else if (set_phase_i) begin
            ifmap_pop_total_o <= '0;   // new preheat
            ipsum_pop_total_o <= '0;
        end else begin
            ifmap_pop_total_o <= ifmap_pop_total_o + ifmap_inc;
            ipsum_pop_total_o <= ipsum_pop_total_o + ipsum_inc;
        end
    end

endmodule : preheat_status

// File: src/preheat_top.sv
//==========================================================
// preheat subsystem top, FIFO readiness in as levels, pops out as strobes
// layer inputs must hold from start until the cycle after start
//==========================================================
`timescale 1ns/1ps

module preheat_top #(
    parameter int NUM_IFMAP_FIFO = 32,   // 1 to 32
    parameter int NUM_IPSUM_FIFO = 32    // 1 to 32
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_preheat_i,
    input  logic [1:0]                layer_type_i,
    input  logic [7:0]                ic_real_i,
    input  logic [7:0]                oc_real_i,
    input  logic [NUM_IFMAP_FIFO-1:0] ifmap_ready_i,
    input  logic [NUM_IPSUM_FIFO-1:0] ipsum_ready_i,
    output logic [NUM_IFMAP_FIFO-1:0] ifmap_pop_o,
    output logic [NUM_IPSUM_FIFO-1:0] ipsum_pop_o,
    output logic [15:0]               ifmap_pop_total_o,
    output logic [15:0]               ipsum_pop_total_o,
    output logic                      busy_o,
    output logic                      opsum_push_one_o,
    output logic                      preheat_done_o
);
    import layer_pkg::*;

    logic set_phase;   // ctrl in set state

    preheat_plan_if #(
        .NUM_IFMAP_FIFO(NUM_IFMAP_FIFO),
        .NUM_IPSUM_FIFO(NUM_IPSUM_FIFO)
    ) plan_if ();

    fifo_prog_if #(
        .NUM_IFMAP_FIFO(NUM_IFMAP_FIFO),
        .NUM_IPSUM_FIFO(NUM_IPSUM_FIFO)
    ) prog_if ();

    //==========================================================
    // decode, execute, result
    //==========================================================
    layer_decode #(
        .NUM_IFMAP_FIFO(NUM_IFMAP_FIFO),
        .NUM_IPSUM_FIFO(NUM_IPSUM_FIFO)
    ) u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .set_phase_i  (set_phase),
        .layer_type_i (layer_type_e'(layer_type_i)),
        .ic_real_i    (ic_real_i),
        .oc_real_i    (oc_real_i),
        .plan         (plan_if)
    );

    fifo_pop_engine #(
        .NUM_IFMAP_FIFO(NUM_IFMAP_FIFO),
        .NUM_IPSUM_FIFO(NUM_IPSUM_FIFO)
    ) u_engine (
        .clk           (clk),
        .rst_n         (rst_n),
        .ifmap_ready_i (ifmap_ready_i),
        .ipsum_ready_i (ipsum_ready_i),
        .plan          (plan_if),
        .prog          (prog_if)
    );

    preheat_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .start_preheat_i  (start_preheat_i),
        .prog             (prog_if),
        .set_phase_o      (set_phase),
        .busy_o           (busy_o),
        .opsum_push_one_o (opsum_push_one_o),
        .preheat_done_o   (preheat_done_o)
    );

    preheat_status #(
        .NUM_IFMAP_FIFO(NUM_IFMAP_FIFO),
        .NUM_IPSUM_FIFO(NUM_IPSUM_FIFO)
    ) u_status (
        .clk               (clk),
        .rst_n             (rst_n),
        .set_phase_i       (set_phase),
        .prog              (prog_if),
        .ifmap_pop_total_o (ifmap_pop_total_o),
        .ipsum_pop_total_o (ipsum_pop_total_o)
    );

    assign ifmap_pop_o = prog_if.ifmap_pop;   // pop strobes to the FIFOs
    assign ipsum_pop_o = prog_if.ipsum_pop;

endmodule : preheat_top

// File: verif/tb_clkgen.sv
//==========================================================
// testbench clock and reset, 10 ns period
// rst_n is released 1 ns after the tenth rising edge
//==========================================================
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int HALF_PERIOD = 5,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;   // off the edge, like all other stimulus
    end

endmodule : tb_clkgen

// File: verif/tb_preheat.sv
//==========================================================
// table driven preheat testbench with 32 FIFOs per side
// inputs change 1 ns after posedge, outputs are sampled at negedge
//==========================================================
`timescale 1ns/1ps

module tb_preheat;
    import layer_pkg::*;
    import fifo_pkg::*;

    localparam int NUM_FIFO = 32;
    localparam int NUM_ROWS = 14;
    localparam int DONE_TIMEOUT = 2000;   // cycles per preheat

    typedef struct {
        layer_type_e lt;
        ch_cnt_t     ic;
        ch_cnt_t     oc;
        logic        stall;   // random ready pattern
    } row_t;

    logic clk, rst_n;
    logic start, stall_mode;
    layer_type_e layer_type;
    ch_cnt_t ic_real, oc_real;
    logic [NUM_FIFO-1:0] ifmap_ready, ipsum_ready, ifmap_pop, ipsum_pop;
    pop_total_t ifmap_total, ipsum_total;
    logic busy, opsum_push, done;

    row_t rows [NUM_ROWS];
    int   ifmap_seen [NUM_FIFO];   // pops counted at the ports
    int   ipsum_seen [NUM_FIFO];
    int   err_cnt, rows_ok, cyc, set_cyc, done_cyc, done_cnt;
    logic busy_q, done_q;
    logic [31:0] rng;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    preheat_top #(
        .NUM_IFMAP_FIFO(NUM_FIFO),
        .NUM_IPSUM_FIFO(NUM_FIFO)
    ) dut0 (
        .clk(clk), .rst_n(rst_n), .start_preheat_i(start),
        .layer_type_i(layer_type), .ic_real_i(ic_real), .oc_real_i(oc_real),
        .ifmap_ready_i(ifmap_ready), .ipsum_ready_i(ipsum_ready),
        .ifmap_pop_o(ifmap_pop), .ipsum_pop_o(ipsum_pop),
        .ifmap_pop_total_o(ifmap_total), .ipsum_pop_total_o(ipsum_total),
        .busy_o(busy), .opsum_push_one_o(opsum_push), .preheat_done_o(done)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    //==========================================================
    // reference model from the decode rules
    //==========================================================
    function automatic pop_cnt_t model_ifmap(input layer_type_e lt, input ch_cnt_t ic,
                                             input int j);
        int span;
        span = (lt == DEPTHWISE || lt == STANDARD) ? 3 * int'(ic) : int'(ic);
        if (j >= span)
            return '0;
        if (lt == DEPTHWISE)
            return pop_cnt_t'((j / 3 + 1) * 3);
        return (lt == STANDARD) ? pop_cnt_t'(3) : pop_cnt_t'(1);
    endfunction

    function automatic pop_cnt_t model_ipsum(input ch_cnt_t oc, input int k);
        return (k < int'(oc)) ? pop_cnt_t'(1) : pop_cnt_t'(0);
    endfunction

    task automatic check_pop_cnt(input string what, input int idx, input pop_cnt_t got,
                                 input pop_cnt_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s FIFO %0d popped %0d times, expected %0d",
                     $time, what, idx, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_total(input string what, input pop_total_t got,
                               input pop_total_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s total %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // ready levels, all high or a fresh random word each cycle
    always @(posedge clk) begin
        #1;
        if (stall_mode) begin
            rng = xorshift(rng);
            ifmap_ready = rng;
            rng = xorshift(rng);
            ipsum_ready = rng;
        end else begin
            ifmap_ready = '1;
            ipsum_ready = '1;
        end
    end

    //==========================================================
    // port monitor, counts pops and watches the control pulses
    //==========================================================
    always @(negedge clk) begin
        cyc++;
        if (rst_n) begin
            for (int i = 0; i < NUM_FIFO; i++) begin
                if (ifmap_pop[i]) ifmap_seen[i]++;
                if (ipsum_pop[i]) ipsum_seen[i]++;
            end
            if (((ifmap_pop & ~ifmap_ready) | (ipsum_pop & ~ipsum_ready)) != '0) begin
                $display("pop on a FIFO whose ready was low at %0t", $time);
                err_cnt++;
            end
            if (done !== opsum_push) begin
                $display("done and opsum push pulses disagree at %0t", $time);
                err_cnt++;
            end
            if (done && done_q) begin
                $display("done pulse lasted more than one cycle at %0t", $time);
                err_cnt++;
            end
            if (busy && !busy_q) set_cyc = cyc;   // first cycle of set
            if (done) begin
                done_cnt++;
                done_cyc = cyc;
            end
            busy_q = busy;
            done_q = done;
        end
    end

    task automatic run_row(input int r);
        int         guard;
        int         err_before;
        logic       seen_done;
        pop_cnt_t   exp_cnt;
        pop_total_t exp_ifmap, exp_ipsum;
        layer_type_e lt;
        lt = rows[r].lt;
        err_before = err_cnt;
        exp_ifmap = '0;
        exp_ipsum = '0;
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_FIFO; i++) begin
            ifmap_seen[i] = 0;
            ipsum_seen[i] = 0;
        end
        done_cnt = 0;
        set_cyc = -1;
        done_cyc = -1;
        stall_mode = rows[r].stall;
        layer_type = lt;
        ic_real = rows[r].ic;
        oc_real = rows[r].oc;
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        @(posedge clk);
        #1 start = 1'b1;   // lands in set or wait, must be ignored
        @(posedge clk);
        #1 start = 1'b0;

        seen_done = 1'b0;
        guard = 0;
        while (!seen_done && guard < DONE_TIMEOUT) begin
            @(negedge clk);
            seen_done = done;
            guard++;
        end
        if (!seen_done)
            abort_run($sformatf("no done pulse within %0d cycles in row %0d", DONE_TIMEOUT, r));
        repeat (4) @(negedge clk);   // room for a wrongly restarted preheat
        @(posedge clk);
        #1;

        for (int i = 0; i < NUM_FIFO; i++) begin
            exp_cnt = model_ifmap(lt, rows[r].ic, i);
            exp_ifmap = exp_ifmap + pop_total_t'(exp_cnt);
            check_pop_cnt("ifmap", i, pop_cnt_t'(ifmap_seen[i]), exp_cnt);
            exp_cnt = model_ipsum(rows[r].oc, i);
            exp_ipsum = exp_ipsum + pop_total_t'(exp_cnt);
            check_pop_cnt("ipsum", i, pop_cnt_t'(ipsum_seen[i]), exp_cnt);
        end
        check_total("ifmap", ifmap_total, exp_ifmap);
        check_total("ipsum", ipsum_total, exp_ipsum);
        if (done_cnt != 1 || busy) begin
            $display("start while busy was not ignored, %0d done pulses", done_cnt);
            err_cnt++;
        end
        if (exp_ifmap == '0 && exp_ipsum == '0 && done_cyc - set_cyc != 2) begin
            $display("empty plan finished %0d cycles after set, not 2", done_cyc - set_cyc);
            err_cnt++;
        end
        if (err_cnt == err_before)
            rows_ok++;
        $display("row %0d %s ic=%0d oc=%0d %s: %s", r, lt.name(), rows[r].ic, rows[r].oc,
                 rows[r].stall ? "stall" : "ready", (err_cnt == err_before) ? "ok" : "failed");
    endtask

    //==========================================================
    // main sequence
    //==========================================================
    initial begin
        int guard;
        start = 1'b0;
        stall_mode = 1'b0;
        layer_type = POINTWISE;
        ic_real = '0;
        oc_real = '0;
        ifmap_ready = '1;
        ipsum_ready = '1;
        err_cnt = 0;
        rows_ok = 0;
        cyc = 0;
        done_cnt = 0;
        busy_q = 1'b0;
        done_q = 1'b0;
        rng = 32'h1cc7bb0f;
        rows = '{
            '{POINTWISE, 8'd0,  8'd0,  1'b0},   // empty plan
            '{POINTWISE, 8'd5,  8'd4,  1'b0},
            '{LINEAR,    8'd32, 8'd32, 1'b0},
            '{POINTWISE, 8'd40, 8'd40, 1'b0},   // capped at 32
            '{LINEAR,    8'd0,  8'd7,  1'b0},
            '{DEPTHWISE, 8'd1,  8'd1,  1'b0},
            '{DEPTHWISE, 8'd10, 8'd16, 1'b0},
            '{DEPTHWISE, 8'd11, 8'd32, 1'b0},   // 33 rows wanted
            '{STANDARD,  8'd4,  8'd8,  1'b0},
            '{STANDARD,  8'd20, 8'd3,  1'b0},
            '{DEPTHWISE, 8'd11, 8'd32, 1'b1},
            '{STANDARD,  8'd4,  8'd8,  1'b1},
            '{POINTWISE, 8'd40, 8'd40, 1'b1},
            '{DEPTHWISE, 8'd10, 8'd16, 1'b1}
        };

        guard = 0;
        while (!rst_n && guard < 50) begin
            @(posedge clk);
            guard++;
        end
        if (!rst_n)
            abort_run("reset never released");
        @(negedge clk);
        if (busy || done || opsum_push || ifmap_pop != '0 || ipsum_pop != '0 ||
            ifmap_total != '0 || ipsum_total != '0) begin
            $display("outputs not quiet after reset at %0t", $time);
            err_cnt++;
        end

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);

        $display("%0d of %0d rows passed, %0d errors", rows_ok, NUM_ROWS, err_cnt);
        if (err_cnt == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule : tb_preheat

// File: project.f
src/layer_pkg.sv
src/fifo_pkg.sv
src/preheat_if.sv
src/layer_decode.sv
src/preheat_ctrl.sv
src/fifo_pop_engine.sv
src/preheat_status.sv
src/preheat_top.sv
verif/tb_clkgen.sv
verif/tb_preheat.sv

// File: run.sh
#!/bin/sh
# build the preheat testbench with Verilator, run it, and judge the log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_preheat -o tb_preheat \
    && ./obj_dir/tb_preheat > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^RESULT: PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
